// ==== verilog/sys_defines.svh ====
`ifndef SYS_DEFINES_SVH
`define SYS_DEFINES_SVH

`define XLEN 32

// Read-only id values
`define MVENDORID_VALUE `XLEN'h7973_7978
`define MARCHID_VALUE `XLEN'h015f_de6d

// MPP set to machine mode
`define MSTATUS_TRAP_VALUE `XLEN'h0000_1800

`define CAUSE_ECALL `XLEN'd11
`define CAUSE_ILLEGAL `XLEN'd2

`endif

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

	typedef enum logic [3:0] {
		OP_CSRRW,
		OP_CSRRS,
		OP_CSRRC,
		OP_CSRRWI,
		OP_CSRRSI,
		OP_CSRRCI,
		OP_ECALL,
		OP_MRET,
		OP_ILLEGAL
	} sys_op_t;

	localparam logic [6:0] SYSTEM_OPCODE = 7'b111_0011;

	localparam logic [2:0] F3_PRIV = 3'b000; // ecall, ebreak, mret, wfi
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [2:0] F3_CSRRC = 3'b011;
	localparam logic [2:0] F3_CSRRWI = 3'b101;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;

	// Field positions in the instruction word
	localparam int OPCODE_LSB = 0;
	localparam int RD_LSB = 7;
	localparam int FUNCT3_LSB = 12;
	localparam int RS1_LSB = 15;
	localparam int IMM_LSB = 20;

	localparam logic [11:0] IMM_ECALL = 12'h000;
	localparam logic [11:0] IMM_MRET = 12'h302;

endpackage

// ==== verilog/csr_pkg.sv ====
package csr_pkg;

	// Machine CSRs that exist in this core
	typedef enum logic [11:0] {
		CSR_MSTATUS = 12'h300,
		CSR_MTVEC = 12'h305,
		CSR_MEPC = 12'h341,
		CSR_MCAUSE = 12'h342,
		CSR_MVENDORID = 12'hf11,
		CSR_MARCHID = 12'hf12
	} csr_addr_t;

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_DONE = 1'b1 // result held for writeback
	} sys_state_t;

endpackage

// ==== verilog/sys_decoder.sv ====
`include "sys_defines.svh"

module sys_decoder (
	input logic [`XLEN-1:0] inst,
	output isa_pkg::sys_op_t op,
	output logic [11:0] csr_addr,
	output logic src_zero,
	output logic [4:0] uimm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] rd_field;
	logic [4:0] rs1_field;
	logic [11:0] imm_field;
	logic regs_zero;

	assign opcode = inst[isa_pkg::OPCODE_LSB +: 7];
	assign rd_field = inst[isa_pkg::RD_LSB +: 5];
	assign funct3 = inst[isa_pkg::FUNCT3_LSB +: 3];
	assign rs1_field = inst[isa_pkg::RS1_LSB +: 5];
	assign imm_field = inst[isa_pkg::IMM_LSB +: 12];

	assign regs_zero = (rd_field == 5'd0) && (rs1_field == 5'd0); // Privileged forms need both zero

	assign csr_addr = imm_field;
	assign uimm = rs1_field; // Immediate forms reuse the rs1 slot
	assign src_zero = (rs1_field == 5'd0);

	always_comb begin
		op = isa_pkg::OP_ILLEGAL;
		if (opcode == isa_pkg::SYSTEM_OPCODE) begin
			case (funct3)
				isa_pkg::F3_PRIV: begin
					if (regs_zero && imm_field == isa_pkg::IMM_ECALL)
						op = isa_pkg::OP_ECALL;
					else if (regs_zero && imm_field == isa_pkg::IMM_MRET)
						op = isa_pkg::OP_MRET;
				end
				isa_pkg::F3_CSRRW: op = isa_pkg::OP_CSRRW;
				isa_pkg::F3_CSRRS: op = isa_pkg::OP_CSRRS;
				isa_pkg::F3_CSRRC: op = isa_pkg::OP_CSRRC;
				isa_pkg::F3_CSRRWI: op = isa_pkg::OP_CSRRWI;
				isa_pkg::F3_CSRRSI: op = isa_pkg::OP_CSRRSI;
				isa_pkg::F3_CSRRCI: op = isa_pkg::OP_CSRRCI;
				default: op = isa_pkg::OP_ILLEGAL; // funct3 100 is reserved
			endcase
		end
	end

endmodule

// ==== verilog/csr_file.sv ====
`include "sys_defines.svh"

module csr_file (
	input logic clock,
	input logic reset,
	input logic [11:0] csr_addr,
	input logic wr_en,
	input logic [`XLEN-1:0] wr_data,
	input logic trap_en,
	input logic [`XLEN-1:0] trap_cause,
	input logic [`XLEN-1:0] trap_pc,
	input logic mret_en,
	output logic [`XLEN-1:0] rd_value,
	output logic [`XLEN-1:0] mstatus,
	output logic [`XLEN-1:0] mtvec,
	output logic [`XLEN-1:0] mepc
);

	logic [`XLEN-1:0] mcause;

	// Read side
	always_comb begin
		case (csr_addr)
			csr_pkg::CSR_MSTATUS: rd_value = mstatus;
			csr_pkg::CSR_MTVEC: rd_value = mtvec;
			csr_pkg::CSR_MEPC: rd_value = mepc;
			csr_pkg::CSR_MCAUSE: rd_value = mcause;
			csr_pkg::CSR_MVENDORID: rd_value = `MVENDORID_VALUE;
			csr_pkg::CSR_MARCHID: rd_value = `MARCHID_VALUE;
			default: rd_value = '0; // Unimplemented reads as zero
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (trap_en) begin
			mstatus <= `MSTATUS_TRAP_VALUE;
			mepc <= trap_pc;
			mcause <= trap_cause;
		end else if (mret_en) begin
			mstatus <= '0;
		end else if (wr_en) begin
			case (csr_addr)
				csr_pkg::CSR_MSTATUS: mstatus <= wr_data;
				csr_pkg::CSR_MTVEC: mtvec <= wr_data;
				csr_pkg::CSR_MEPC: mepc <= wr_data;
				csr_pkg::CSR_MCAUSE: mcause <= wr_data;
				default: ; // Ids and unknown addresses drop the write
			endcase
		end
	end

endmodule

// ==== verilog/sys_exec.sv ====
`include "sys_defines.svh"

module sys_exec (
	input logic clock,
	input logic reset,
	input logic start,
	input logic wb_accept,
	input isa_pkg::sys_op_t op,
	input logic [11:0] csr_addr_in,
	input logic src_zero,
	input logic [4:0] uimm,
	input logic [`XLEN-1:0] src1,
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] rd_value,
	input logic [`XLEN-1:0] mtvec,
	input logic [`XLEN-1:0] mepc,
	output logic [11:0] csr_addr,
	output logic wr_en,
	output logic [`XLEN-1:0] wr_data,
	output logic trap_en,
	output logic [`XLEN-1:0] trap_cause,
	output logic [`XLEN-1:0] trap_pc,
	output logic mret_en,
	output logic done,
	output logic [`XLEN-1:0] rd_data,
	output logic rd_write,
	output logic [`XLEN-1:0] next_pc,
	output logic trap
);

	csr_pkg::sys_state_t state;

	logic fire;
	logic is_csr;
	logic is_imm;
	logic is_trap;
	logic skip_write;
	logic [`XLEN-1:0] operand;
	logic [`XLEN-1:0] target_pc;

	// Side effects only in the accepting cycle
	assign fire = (state == csr_pkg::ST_IDLE) && start;
	assign done = (state == csr_pkg::ST_DONE);

	assign csr_addr = csr_addr_in;

	assign is_imm = (op == isa_pkg::OP_CSRRWI) || (op == isa_pkg::OP_CSRRSI) ||
		(op == isa_pkg::OP_CSRRCI);
	assign operand = is_imm ? {{(`XLEN-5){1'b0}}, uimm} : src1;

	always_comb begin
		is_csr = 1'b1;
		skip_write = 1'b0;
		wr_data = operand;
		case (op)
			isa_pkg::OP_CSRRW, isa_pkg::OP_CSRRWI: wr_data = operand;
			isa_pkg::OP_CSRRS, isa_pkg::OP_CSRRSI: begin
				wr_data = rd_value | operand;
				skip_write = src_zero; // Pure read
			end
			isa_pkg::OP_CSRRC, isa_pkg::OP_CSRRCI: begin
				wr_data = rd_value & ~operand;
				skip_write = src_zero;
			end
			default: begin
				is_csr = 1'b0;
				skip_write = 1'b1;
			end
		endcase
	end

	assign wr_en = fire && is_csr && !skip_write;

	assign is_trap = (op == isa_pkg::OP_ECALL) || (op == isa_pkg::OP_ILLEGAL);
	assign trap_en = fire && is_trap;
	assign trap_cause = (op == isa_pkg::OP_ECALL) ? `CAUSE_ECALL : `CAUSE_ILLEGAL;
	assign trap_pc = pc;
	assign mret_en = fire && (op == isa_pkg::OP_MRET);

	// Values before this instruction's own update
	always_comb begin
		if (is_trap)
			target_pc = mtvec;
		else if (op == isa_pkg::OP_MRET)
			target_pc = mepc;
		else
			target_pc = pc + `XLEN'd4;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= csr_pkg::ST_IDLE;
			rd_write <= 1'b0;
			trap <= 1'b0;
		end else begin
			case (state)
				csr_pkg::ST_IDLE: begin
					if (start) begin
						state <= csr_pkg::ST_DONE;
						rd_write <= is_csr;
						trap <= is_trap;
					end
				end
				csr_pkg::ST_DONE: begin
					if (wb_accept)
						state <= csr_pkg::ST_IDLE;
				end
				default: state <= csr_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			rd_data <= is_csr ? rd_value : '0;
			next_pc <= target_pc;
		end
	end

endmodule

// ==== verilog/sys_unit.sv ====
`include "sys_defines.svh"

module sys_unit (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [`XLEN-1:0] inst,
	input logic [`XLEN-1:0] src1,
	input logic [`XLEN-1:0] pc,
	input logic wb_accept,
	output logic done,
	output logic [`XLEN-1:0] rd_data,
	output logic rd_write,
	output logic [`XLEN-1:0] next_pc,
	output logic trap,
	output logic [`XLEN-1:0] mstatus
);

	isa_pkg::sys_op_t op;
	logic [11:0] dec_csr_addr; // Straight from the instruction
	logic src_zero;
	logic [4:0] uimm;

	logic [11:0] csr_addr;
	logic wr_en;
	logic [`XLEN-1:0] wr_data;
	logic trap_en;
	logic [`XLEN-1:0] trap_cause;
	logic [`XLEN-1:0] trap_pc;
	logic mret_en;

	logic [`XLEN-1:0] rd_value;
	logic [`XLEN-1:0] mtvec;
	logic [`XLEN-1:0] mepc;

	sys_decoder sys_decoder_i (
		.inst(inst),
		.op(op),
		.csr_addr(dec_csr_addr),
		.src_zero(src_zero),
		.uimm(uimm)
	);

	sys_exec sys_exec_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.wb_accept(wb_accept),
		.op(op),
		.csr_addr_in(dec_csr_addr),
		.src_zero(src_zero),
		.uimm(uimm),
		.src1(src1),
		.pc(pc),
		.rd_value(rd_value),
		.mtvec(mtvec),
		.mepc(mepc),
		.csr_addr(csr_addr),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.trap_en(trap_en),
		.trap_cause(trap_cause),
		.trap_pc(trap_pc),
		.mret_en(mret_en),
		.done(done),
		.rd_data(rd_data),
		.rd_write(rd_write),
		.next_pc(next_pc),
		.trap(trap)
	);

	csr_file csr_file_i (
		.clock(clock),
		.reset(reset),
		.csr_addr(csr_addr),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.trap_en(trap_en),
		.trap_cause(trap_cause),
		.trap_pc(trap_pc),
		.mret_en(mret_en),
		.rd_value(rd_value),
		.mstatus(mstatus),
		.mtvec(mtvec),
		.mepc(mepc)
	);

endmodule

// ==== test/sys_unit_tb.sv ====
`include "sys_defines.svh"

module sys_unit_tb;

	localparam int CLOCK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TRANS = 400;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TRANS * 8;

	typedef struct packed {
		logic [`XLEN-1:0] rd_data;
		logic rd_write;
		logic [`XLEN-1:0] next_pc;
		logic trap;
		logic [`XLEN-1:0] mstatus;
	} result_t;

	logic clock = 1'b0;
	logic reset;
	logic start;
	logic [`XLEN-1:0] inst;
	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] pc;
	logic wb_accept;
	logic done;
	logic [`XLEN-1:0] rd_data;
	logic rd_write;
	logic [`XLEN-1:0] next_pc;
	logic trap;
	logic [`XLEN-1:0] mstatus;

	logic [31:0] lfsr_state = 32'hf645_ee29;
	logic [`XLEN-1:0] model_mstatus = '0; // Reference copy of the CSRs
	logic [`XLEN-1:0] model_mtvec = '0;
	logic [`XLEN-1:0] model_mepc = '0;
	logic [`XLEN-1:0] model_mcause = '0;
	result_t expect_q[$];
	int checked_count = 0;

	sys_unit sys_unit_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.inst(inst),
		.src1(src1),
		.pc(pc),
		.wb_accept(wb_accept),
		.done(done),
		.rd_data(rd_data),
		.rd_write(rd_write),
		.next_pc(next_pc),
		.trap(trap),
		.mstatus(mstatus)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [`XLEN-1:0] build_inst();
		logic [31:0] kind;
		logic [31:0] pick;
		logic [31:0] rd_bits;
		logic [31:0] rs1_bits;
		logic [31:0] word;
		logic [11:0] addr;
		logic [2:0] funct3;
		logic [4:0] rs1_field;
		kind = take_bits(4);
		rd_bits = take_bits(5);
		if (kind < 32'd11) begin
			pick = take_bits(3);
			case (pick[2:0])
				3'd0: addr = csr_pkg::CSR_MSTATUS;
				3'd1: addr = csr_pkg::CSR_MTVEC;
				3'd2: addr = csr_pkg::CSR_MEPC;
				3'd3: addr = csr_pkg::CSR_MCAUSE;
				3'd4: addr = csr_pkg::CSR_MVENDORID;
				3'd5: addr = csr_pkg::CSR_MARCHID;
				3'd6: addr = 12'h340; // mscratch is not implemented
				default: addr = 12'hb00;
			endcase
			pick = take_bits(3);
			case (pick[2:0])
				3'd0: funct3 = isa_pkg::F3_CSRRW;
				3'd1: funct3 = isa_pkg::F3_CSRRS;
				3'd2: funct3 = isa_pkg::F3_CSRRC;
				3'd3: funct3 = isa_pkg::F3_CSRRWI;
				3'd4: funct3 = isa_pkg::F3_CSRRSI;
				3'd5: funct3 = isa_pkg::F3_CSRRCI;
				3'd6: funct3 = isa_pkg::F3_CSRRW;
				default: funct3 = isa_pkg::F3_CSRRS;
			endcase
			pick = take_bits(2);
			rs1_bits = take_bits(5);
			rs1_field = (pick[1:0] == 2'd0) ? 5'd0 : rs1_bits[4:0]; // Zero source now and then
			word = {addr, rs1_field, funct3, rd_bits[4:0], isa_pkg::SYSTEM_OPCODE};
		end else if (kind == 32'd11) begin
			word = {isa_pkg::IMM_ECALL, 5'd0, isa_pkg::F3_PRIV, 5'd0, isa_pkg::SYSTEM_OPCODE};
		end else if (kind == 32'd12 || kind == 32'd15) begin
			word = {isa_pkg::IMM_MRET, 5'd0, isa_pkg::F3_PRIV, 5'd0, isa_pkg::SYSTEM_OPCODE};
		end else if (kind == 32'd13) begin
			pick = take_bits(2);
			rs1_bits = take_bits(32);
			case (pick[1:0])
				2'd0: word = {rs1_bits[31:15], 3'b100, rs1_bits[11:7], isa_pkg::SYSTEM_OPCODE};
				2'd1: word = {12'h001, 5'd0, isa_pkg::F3_PRIV, 5'd0, isa_pkg::SYSTEM_OPCODE};
				2'd2: word = {12'h105, 5'd0, isa_pkg::F3_PRIV, 5'd0, isa_pkg::SYSTEM_OPCODE};
				default: word = {isa_pkg::IMM_ECALL, 5'd0, isa_pkg::F3_PRIV,
					rd_bits[4:0] | 5'd1, isa_pkg::SYSTEM_OPCODE}; // ecall with rd set
			endcase
		end else begin
			word = take_bits(32);
			if (word[6:0] == isa_pkg::SYSTEM_OPCODE)
				word[6:0] = 7'b011_0011;
		end
		return word;
	endfunction

	function automatic logic [`XLEN-1:0] model_read(input logic [11:0] addr);
		case (addr)
			csr_pkg::CSR_MSTATUS: return model_mstatus;
			csr_pkg::CSR_MTVEC: return model_mtvec;
			csr_pkg::CSR_MEPC: return model_mepc;
			csr_pkg::CSR_MCAUSE: return model_mcause;
			csr_pkg::CSR_MVENDORID: return `MVENDORID_VALUE;
			csr_pkg::CSR_MARCHID: return `MARCHID_VALUE;
			default: return '0;
		endcase
	endfunction

	function automatic void model_write(input logic [11:0] addr, input logic [`XLEN-1:0] value);
		case (addr)
			csr_pkg::CSR_MSTATUS: model_mstatus = value;
			csr_pkg::CSR_MTVEC: model_mtvec = value;
			csr_pkg::CSR_MEPC: model_mepc = value;
			csr_pkg::CSR_MCAUSE: model_mcause = value;
			default: ;
		endcase
	endfunction

	// Applies one accepted instruction to the model CSRs
	function automatic result_t model_step(input logic [`XLEN-1:0] word,
		input logic [`XLEN-1:0] rs1_value, input logic [`XLEN-1:0] inst_pc);
		logic [2:0] funct3;
		logic [4:0] rd_field;
		logic [4:0] rs1_field;
		logic [11:0] imm;
		logic priv_ok;
		logic is_csr_op;
		logic [`XLEN-1:0] old_value;
		logic [`XLEN-1:0] operand;
		logic [`XLEN-1:0] new_value;
		result_t res;
		funct3 = word[14:12];
		rd_field = word[11:7];
		rs1_field = word[19:15];
		imm = word[31:20];
		priv_ok = (rd_field == 5'd0) && (rs1_field == 5'd0);
		is_csr_op = (word[6:0] == isa_pkg::SYSTEM_OPCODE) && (funct3 != isa_pkg::F3_PRIV) &&
			(funct3 != 3'b100);
		res = '0;
		res.rd_write = is_csr_op;
		if (is_csr_op) begin
			old_value = model_read(imm);
			operand = funct3[2] ? {{(`XLEN-5){1'b0}}, rs1_field} : rs1_value;
			case (funct3)
				isa_pkg::F3_CSRRW, isa_pkg::F3_CSRRWI: new_value = operand;
				isa_pkg::F3_CSRRS, isa_pkg::F3_CSRRSI: new_value = old_value | operand;
				default: new_value = old_value & ~operand;
			endcase
			if (funct3 == isa_pkg::F3_CSRRW || funct3 == isa_pkg::F3_CSRRWI || rs1_field != 5'd0)
				model_write(imm, new_value);
			res.rd_data = old_value;
			res.next_pc = inst_pc + `XLEN'd4;
		end else if (word[6:0] == isa_pkg::SYSTEM_OPCODE && funct3 == isa_pkg::F3_PRIV &&
			priv_ok && imm == isa_pkg::IMM_MRET) begin
			res.next_pc = model_mepc;
			model_mstatus = '0;
		end else begin
			res.trap = 1'b1;
			res.next_pc = model_mtvec; // Trap vector before this trap
			model_mepc = inst_pc;
			if (word[6:0] == isa_pkg::SYSTEM_OPCODE && funct3 == isa_pkg::F3_PRIV &&
				priv_ok && imm == isa_pkg::IMM_ECALL)
				model_mcause = `CAUSE_ECALL;
			else
				model_mcause = `CAUSE_ILLEGAL;
			model_mstatus = `MSTATUS_TRAP_VALUE;
		end
		res.mstatus = model_mstatus;
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("test failed");
			$fatal(1, "output check failed");
		end
	endtask

	// Stimulus
	initial begin
		logic [31:0] r;
		int hold;
		reset = 1'b1;
		start = 1'b0;
		inst = '0;
		src1 = '0;
		pc = '0;
		wb_accept = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int n = 0; n < NUM_TRANS; n++) begin
			inst = build_inst();
			src1 = take_bits(32);
			r = take_bits(30);
			pc = {r[29:0], 2'b00};
			start = 1'b1;
			expect_q.push_back(model_step(inst, src1, pc));
			@(posedge clock);
			#1;
			start = 1'b0;
			while (done !== 1'b1) begin
				@(posedge clock);
				#1;
			end
			hold = take_bits(2);
			for (int k = 0; k < hold; k++) begin
				r = take_bits(1);
				if (r[0]) begin
					start = 1'b1; // Must be ignored while done is high
					inst = build_inst();
					src1 = take_bits(32);
					pc = take_bits(32);
				end
				@(posedge clock);
				#1;
				start = 1'b0;
			end
			wb_accept = 1'b1;
			@(posedge clock);
			#1;
			wb_accept = 1'b0;
		end
		@(posedge clock);
		#1;
		if (checked_count == NUM_TRANS && expect_q.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("Only %0d of %0d results were seen", checked_count, NUM_TRANS);
			$display("test failed");
			$fatal(1, "missing results");
		end
	end

	// Compare at the falling edge away from input changes
	initial begin
		result_t exp_res;
		logic holding;
		logic accepted;
		holding = 1'b0;
		accepted = 1'b0;
		exp_res = '0;
		forever begin
			@(negedge clock);
			if (accepted) begin
				check_value("done after accept", 32'(done), 32'd0);
				accepted = 1'b0;
			end else if (done === 1'b1) begin
				if (!holding && expect_q.size() == 0) begin
					$display("Done rose at %0t with no request pending", $time);
					$display("test failed");
					$fatal(1, "unexpected done");
				end else begin
					if (!holding) begin
						exp_res = expect_q.pop_front();
						holding = 1'b1;
						checked_count++;
					end
					if (exp_res.rd_write)
						check_value("rd_data", rd_data, exp_res.rd_data);
					check_value("rd_write", 32'(rd_write), 32'(exp_res.rd_write));
					check_value("next_pc", next_pc, exp_res.next_pc);
					check_value("trap", 32'(trap), 32'(exp_res.trap));
					check_value("mstatus", mstatus, exp_res.mstatus);
					if (wb_accept) begin
						holding = 1'b0;
						accepted = 1'b1;
					end
				end
			end else if (holding) begin
				check_value("done while waiting", 32'(done), 32'd1);
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("Timeout, the unit stopped responding");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sys_unit.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/csr_pkg.sv
verilog/sys_decoder.sv
verilog/csr_file.sv
verilog/sys_exec.sv
verilog/sys_unit.sv
test/sys_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sys_unit_tb -f sys_unit.f -o sys_unit_sim \
	&& ./obj_dir/sys_unit_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
	&& echo "Simulation result: PASS" \
	|| { echo "Simulation result: FAIL"; exit 1; }

exit 0
